// ==== Bender.yml ====
package:
  name: phs_avg

sources:
  # phs_avg_params.svh is picked up through the include directory
  - include_dirs:
      - .
    files:
      - phs_avg_pkg.sv
      - phs_gain_regs.sv
      - phs_cross_mul.sv
      - phs_avg_accum.sv
      - phs_avg_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - phs_avg_checker.sv
      - phs_avg_tb.sv

// ==== phs_avg_accum.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

module phs_avg_accum (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         int_clear,
	input  phs_avg_pkg::xprod_t          prod_f,
	input  phs_avg_pkg::xprod_t          prod_r,
	output logic signed [`PHS_DWI+7:0]   sum_filt,
	output logic signed [`PHS_DWI+1:0]   z
);

	// one guard bit per addition
	localparam int SUM_W  = $bits(phs_avg_pkg::xprod_t) + 1;
	localparam int FILT_W = `PHS_INTG_W;

	logic signed [SUM_W-1:0]  sum;
	logic signed [SUM_W-1:0]  sum_d;
	logic signed [FILT_W-1:0] sum_f;
	logic signed [FILT_W-1:0] intg;

	// stage 1: forward plus reverse
	// stage 2: two-tap [1, 1] filter over the last two sums
	// this pairs the R*I and I*R halves of each sample
	always_ff @(posedge clk) begin
		if (reset) begin
			sum   <= '0;
			sum_d <= '0;
			sum_f <= '0;
		end else begin
			sum   <= prod_f + prod_r;
			sum_d <= sum;
			sum_f <= sum + sum_d;
		end
	end

	// stage 3: integrator
	// the filter counts every pair twice, so half is added
	always_ff @(posedge clk) begin
		if (reset || int_clear) begin
			intg <= '0;
		end else begin
			intg <= intg + (sum_f >>> 1);
		end
	end

	assign sum_filt = sum_f;

	// phase error
	// the five low integrator bits are fraction
	assign z = intg[`PHS_DWI+6:5];

endmodule

// ==== phs_avg_checker.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

// reset, handshake and interleave rules on the phase averaging top
module phs_avg_checker (
	input logic                         clk,
	input logic                         reset,
	input logic                         awready,
	input logic                         wready,
	input logic                         bvalid,
	input logic                         bready,
	input logic                         arready,
	input logic                         rvalid,
	input logic                         rready,
	input logic [`PHS_AXI_DW-1:0]       rdata,
	input logic                         int_clear,
	input phs_avg_pkg::iq_sample_t      fwd,
	input logic signed [`PHS_DWI+7:0]   sum_filt,
	input logic signed [`PHS_DWI+1:0]   z
);

	// failed assertions so far
	int fail_cnt = 0;

	// datapath outputs are zero once a reset edge has passed
	a_reset_zero: assert property (@(posedge clk) reset |=> (z == '0 && sum_filt == '0))
		else begin
			fail_cnt++;
			$error("z or sum_filt not zero after a reset cycle");
		end

	// no handshake or clear strobe out of reset
	a_reset_idle: assert property (@(posedge clk)
		reset |=> !(awready || wready || bvalid || arready || rvalid || int_clear))
		else begin
			fail_cnt++;
			$error("AXI ready/valid or int_clear high after a reset cycle");
		end

	// write response held until bready
	a_b_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid)
		else begin
			fail_cnt++;
			$error("bvalid dropped before bready");
		end

	// read response and its data held until rready
	a_r_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else begin
			fail_cnt++;
			$error("rvalid or rdata changed before rready");
		end

	// iq alternates every cycle once out of reset
	a_iq_toggle: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> fwd.iq != $past(fwd.iq))
		else begin
			fail_cnt++;
			$error("fwd.iq did not toggle");
		end

endmodule

bind phs_avg_top phs_avg_checker u_checker (
	.clk       (clk),
	.reset     (reset),
	.awready   (awready),
	.wready    (wready),
	.bvalid    (bvalid),
	.bready    (bready),
	.arready   (arready),
	.rvalid    (rvalid),
	.rready    (rready),
	.rdata     (rdata),
	.int_clear (int_clear),
	.fwd       (fwd),
	.sum_filt  (sum_filt),
	.z         (z)
);

// ==== phs_avg_params.svh ====
`ifndef PHS_AVG_PARAMS_SVH
`define PHS_AVG_PARAMS_SVH

// sample width of the interleaved forward and reverse streams
// the datapath widths below grow from this value
`define PHS_DWI 17

// width of one gain component, real or imaginary
`define PHS_DWJ 16

// AXI4-Lite byte address width
// four word registers fit in 4 bits
`define PHS_AXI_AW 4

// AXI4-Lite data width
`define PHS_AXI_DW 32

// OKAY response code, the only one this slave returns
`define PHS_AXI_RESP_OKAY 2'b00

// integrator width, also the filter output width
`define PHS_INTG_W (`PHS_DWI + 8)

`endif

// ==== phs_avg_pkg.sv ====
`include "phs_avg_params.svh"

package phs_avg_pkg;

	// one interleaved sample
	// iq high marks the real part, low the imaginary part
	typedef struct packed {
		logic                      iq;
		logic signed [`PHS_DWI-1:0] val;
	} iq_sample_t;

	// complex gain as written by the host
	typedef struct packed {
		logic signed [`PHS_DWJ-1:0] re;
		logic signed [`PHS_DWJ-1:0] im;
	} cgain_t;

	// forward and reverse gains, in that order
	typedef struct packed {
		cgain_t fwd;
		cgain_t rev;
	} gain_set_t;

	// trimmed cross product, one per multiplier
	typedef logic signed [`PHS_DWI+5:0] xprod_t;

	// register byte offsets
	// the 4-bit map has four word slots, so the reverse word carries both
	// components: real in [15:0], imaginary in [31:16]
	typedef enum logic [`PHS_AXI_AW-1:0] {
		REG_FWD_RE = 4'h0,
		REG_FWD_IM = 4'h4,
		REG_REV_RE = 4'h8,
		// bit 0 clears the integrator, reads back zero
		REG_CTRL   = 4'hC
	} reg_addr_e;

endpackage

// ==== phs_avg_stimulus.txt ====
# W addr data = AXI write, R addr data = AXI read and compare, I n = idle cycles
# S iq fwd rev z = one sample cycle, z expected four cycles later; all fields hex
# gains still zero after reset
S 1 00400 00400 00000
S 0 00200 00200 00000
S 1 00400 00400 00000
S 0 00200 00200 00000
# forward 4096 + j1024, reverse word {im, re} holds the negated gain
W 0 00001000
W 4 00000400
W 8 fc00f000
R 0 00001000
R 4 00000400
R 8 fc00f000
R c 00000000
# forward stream alone, z steps by 0x60
S 1 00400 00000 00020
S 0 00200 00000 00080
S 1 00400 00000 000e0
S 0 00200 00000 00140
S 1 00400 00000 001a0
S 0 00200 00000 00200
S 1 00400 00000 00260
S 0 00200 00000 002c0
# filter tail adds 0x40 more
I 6
# equal streams cancel, z holds
S 1 00400 00400 00300
S 0 00200 00200 00300
S 1 00400 00400 00300
S 0 00200 00200 00300
I 6
# integrator clear, then the ramp starts again from zero
W c 00000001
S 1 00000 00000 00000
S 0 00000 00000 00000
S 1 00400 00000 00020
S 0 00200 00000 00080
S 1 00400 00000 000e0
S 0 00200 00000 00140
R c 00000000

// ==== phs_avg_tb.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

module phs_avg_tb;

	localparam int ZW = `PHS_DWI + 2;
	localparam int SW = `PHS_DWI + 8;

	logic                       clk;
	logic                       reset;
	logic [`PHS_AXI_AW-1:0]     awaddr;
	logic                       awvalid;
	logic                       awready;
	logic [`PHS_AXI_DW-1:0]     wdata;
	logic                       wvalid;
	logic                       wready;
	logic [1:0]                 bresp;
	logic                       bvalid;
	logic                       bready;
	logic [`PHS_AXI_AW-1:0]     araddr;
	logic                       arvalid;
	logic                       arready;
	logic [`PHS_AXI_DW-1:0]     rdata;
	logic [1:0]                 rresp;
	logic                       rvalid;
	logic                       rready;
	phs_avg_pkg::iq_sample_t    fwd;
	phs_avg_pkg::iq_sample_t    rev;
	logic signed [SW-1:0]       sum_filt;
	logic signed [ZW-1:0]       z;

	// expected z of the last four cycles
	// slot 3 comes due next
	logic                       exp_v [0:3];
	logic [31:0]                exp_z [0:3];
	// sum_filt must read zero while the gains are untouched
	logic                       sf_zero;
	int                         errors = 0;
	int                         checks = 0;
	int                         cyc = 0;
	int                         limit = 100000;

	tb_clk_gen u_clk (
		.clk   (clk),
		.reset (reset)
	);

	phs_avg_top u_dut (
		.clk      (clk),
		.reset    (reset),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.fwd      (fwd),
		.rev      (rev),
		.sum_filt (sum_filt),
		.z        (z)
	);

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	// one clock cycle
	// the z due from four cycles back is checked before the new sample goes out
	task automatic drive_cycle(input logic iq, input logic [31:0] fv, input logic [31:0] rv,
			input logic has_exp, input logic [31:0] zv);
		int i;
		@(posedge clk);
		#10;
		if (exp_v[3])
			check_val("z", {{(32-ZW){1'b0}}, z}, {{(32-ZW){1'b0}}, exp_z[3][ZW-1:0]});
		if (sf_zero)
			check_val("sum_filt", {{(32-SW){1'b0}}, sum_filt}, 32'd0);
		for (i = 3; i > 0; i--) begin
			exp_v[i] = exp_v[i-1];
			exp_z[i] = exp_z[i-1];
		end
		exp_v[0] = has_exp;
		exp_z[0] = zv;
		fwd.iq   = iq;
		fwd.val  = fv[`PHS_DWI-1:0];
		rev.iq   = iq;
		rev.val  = rv[`PHS_DWI-1:0];
	endtask

	// zero samples with iq still alternating
	task automatic idle_cycle();
		drive_cycle(~fwd.iq, 32'd0, 32'd0, 1'b0, 32'd0);
	endtask

	task automatic sample_cycle(input logic iq, input logic [31:0] fv, input logic [31:0] rv,
			input logic [31:0] zv);
		// one filler cycle if the file's iq would repeat the last one
		if (iq == fwd.iq)
			idle_cycle();
		drive_cycle(iq, fv, rv, 1'b1, zv);
	endtask

	task automatic axi_write(input logic [`PHS_AXI_AW-1:0] addr, input logic [31:0] data);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		idle_cycle();
		while (!awready)
			idle_cycle();
		// wready pulses together with awready
		check_val("wready", {31'd0, wready}, 32'd1);
		// aw and w taken at this edge
		idle_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// response must wait for bready
		repeat (3) idle_cycle();
		check_val("bvalid", {31'd0, bvalid}, 32'd1);
		check_val("bresp", {30'd0, bresp}, 32'd0);
		bready = 1'b1;
		idle_cycle();
		bready = 1'b0;
		check_val("bvalid", {31'd0, bvalid}, 32'd0);
	endtask

	task automatic axi_read(input logic [`PHS_AXI_AW-1:0] addr, input logic [31:0] exp);
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready)
			idle_cycle();
		idle_cycle();
		arvalid = 1'b0;
		repeat (3) idle_cycle();
		check_val("rvalid", {31'd0, rvalid}, 32'd1);
		check_val("rdata", rdata, exp);
		check_val("rresp", {30'd0, rresp}, 32'd0);
		rready = 1'b1;
		idle_cycle();
		rready = 1'b0;
		check_val("rvalid", {31'd0, rvalid}, 32'd0);
	endtask

	// run limit
	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc >= limit) begin
			$display("timeout: stimulus not finished after %0d cycles, %0d errors", cyc, errors);
			$display("Test FAILED");
			$finish;
		end
	end

	initial begin
		int               fd;
		int               n;
		int               n_lines;
		byte              op;
		logic [31:0]      a;
		logic [31:0]      b;
		logic [31:0]      c;
		logic [31:0]      d;
		logic [8*256-1:0] skip;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		fwd     = '0;
		rev     = '0;
		sf_zero = 1'b0;
		for (n = 0; n < 4; n++) begin
			exp_v[n] = 1'b0;
			exp_z[n] = '0;
		end
		fd = $fopen("phs_avg_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open phs_avg_stimulus.txt for reading");
			$display("Test FAILED");
			$finish;
		end else begin
			// first pass sizes the run limit
			n_lines = 0;
			while ($fgets(skip, fd) != 0)
				n_lines++;
			$fclose(fd);
			limit = 2 * n_lines + 200;
			fd = $fopen("phs_avg_stimulus.txt", "r");
			idle_cycle();
			while (reset)
				idle_cycle();
			sf_zero = 1'b1;
			while ($fscanf(fd, " %c", op) == 1) begin
				case (op)
					"#": n = $fgets(skip, fd);
					"W": begin
						n = $fscanf(fd, "%h %h", a, b);
						sf_zero = 1'b0;
						axi_write(a[`PHS_AXI_AW-1:0], b);
					end
					"R": begin
						n = $fscanf(fd, "%h %h", a, b);
						axi_read(a[`PHS_AXI_AW-1:0], b);
					end
					"I": begin
						n = $fscanf(fd, "%h", a);
						repeat (a) idle_cycle();
					end
					"S": begin
						n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
						sample_cycle(a[0], b, c, d);
					end
					default: begin
						errors++;
						$display("unknown record type in the stimulus file");
					end
				endcase
			end
			$fclose(fd);
			// the last four expectations come due
			repeat (4) idle_cycle();
			$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
				u_dut.u_checker.fail_cnt);
			if (errors == 0 && u_dut.u_checker.fail_cnt == 0) begin
				$display("Test OK");
			end else begin
				$display("Test FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== phs_avg_top.f ====
+incdir+.
phs_avg_pkg.sv
phs_gain_regs.sv
phs_cross_mul.sv
phs_avg_accum.sv
phs_avg_top.sv
tb_clk_gen.sv
phs_avg_checker.sv
phs_avg_tb.sv

// ==== phs_avg_top.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

// phase averaging for the LLRF loop
// total latency from a sample pair to z is four cycles
module phs_avg_top (
	input  logic                         clk,
	input  logic                         reset,
	// AXI4-Lite slave
	input  logic [`PHS_AXI_AW-1:0]       awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`PHS_AXI_DW-1:0]       wdata,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  logic [`PHS_AXI_AW-1:0]       araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`PHS_AXI_DW-1:0]       rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	// sample streams
	input  phs_avg_pkg::iq_sample_t      fwd,
	input  phs_avg_pkg::iq_sample_t      rev,
	// results
	output logic signed [`PHS_DWI+7:0]   sum_filt,
	output logic signed [`PHS_DWI+1:0]   z
);

	phs_avg_pkg::gain_set_t  gains;
	phs_avg_pkg::iq_sample_t rev_s;
	phs_avg_pkg::xprod_t     prod_f;
	phs_avg_pkg::xprod_t     prod_r;
	logic                    int_clear;

	// reverse stream follows the forward iq strobe
	assign rev_s.iq  = fwd.iq;
	assign rev_s.val = rev.val;

	phs_gain_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.gains     (gains),
		.int_clear (int_clear)
	);

	phs_cross_mul u_mul_fwd (
		.clk   (clk),
		.reset (reset),
		.samp  (fwd),
		.gain  (gains.fwd),
		.prod  (prod_f)
	);

	phs_cross_mul u_mul_rev (
		.clk   (clk),
		.reset (reset),
		.samp  (rev_s),
		.gain  (gains.rev),
		.prod  (prod_r)
	);

	phs_avg_accum u_accum (
		.clk       (clk),
		.reset     (reset),
		.int_clear (int_clear),
		.prod_f    (prod_f),
		.prod_r    (prod_r),
		.sum_filt  (sum_filt),
		.z         (z)
	);

endmodule

// ==== phs_cross_mul.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

// one multiplier serves both halves of the imaginary term
// iq high: real gain is picked, multiplied next cycle by the imaginary sample
// iq low: imaginary gain is picked, multiplied next cycle by the real sample
// over two cycles this gives R*I and I*R, summed later by the filter
module phs_cross_mul (
	input  logic                    clk,
	input  logic                    reset,
	input  phs_avg_pkg::iq_sample_t samp,
	input  phs_avg_pkg::cgain_t     gain,
	output phs_avg_pkg::xprod_t     prod
);

	localparam int FULL_W = `PHS_DWI + `PHS_DWJ;
	localparam int PROD_W = $bits(phs_avg_pkg::xprod_t);
	// low bits dropped from the full product
	localparam int DROP_W = `PHS_DWI - 8;

	logic signed [`PHS_DWJ-1:0] gain_sel;
	logic signed [`PHS_DWJ-1:0] gain_d;
	logic signed [FULL_W-1:0]   prod_full;

	// component picked by the current iq flag
	assign gain_sel = samp.iq ? gain.re : gain.im;

	// gain delayed by one sample
	always_ff @(posedge clk) begin
		if (reset) begin
			gain_d <= '0;
		end else begin
			gain_d <= gain_sel;
		end
	end

	// registered product, the one cycle of latency
	always_ff @(posedge clk) begin
		if (reset) begin
			prod_full <= '0;
		end else begin
			prod_full <= samp.val * gain_d;
		end
	end

	// middle bits
	// the top bit only repeats the sign, so it goes
	assign prod = prod_full[DROP_W +: PROD_W];

endmodule

// ==== phs_gain_regs.sv ====
`timescale 1ns/10ps
`include "phs_avg_params.svh"

module phs_gain_regs (
	input  logic                         clk,
	input  logic                         reset,
	// write address and data
	input  logic [`PHS_AXI_AW-1:0]       awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  logic [`PHS_AXI_DW-1:0]       wdata,
	input  logic                         wvalid,
	output logic                         wready,
	// write response
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	// read address and data
	input  logic [`PHS_AXI_AW-1:0]       araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output logic [`PHS_AXI_DW-1:0]       rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	// to the datapath
	output phs_avg_pkg::gain_set_t       gains,
	output logic                         int_clear
);

	localparam int EXT_W = `PHS_AXI_DW - `PHS_DWJ;

	// host-visible copy of the gains
	phs_avg_pkg::gain_set_t gain_q;
	logic                   wr_fire;
	logic                   rd_fire;
	logic [`PHS_AXI_DW-1:0] rd_mux;

	// aw and w are accepted together, ready pulses only once both are valid
	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	// every access completes OKAY, unknown offsets included
	assign bresp = `PHS_AXI_RESP_OKAY;
	assign rresp = `PHS_AXI_RESP_OKAY;

	// write channel and gain storage
	always_ff @(posedge clk) begin
		if (reset) begin
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			int_clear <= 1'b0;
			gain_q    <= '0;
		end else begin
			// single-cycle strobes by default
			awready   <= 1'b0;
			wready    <= 1'b0;
			int_clear <= 1'b0;
			if (wr_fire) begin
				bvalid <= 1'b1;
				case (phs_avg_pkg::reg_addr_e'(awaddr))
					phs_avg_pkg::REG_FWD_RE: gain_q.fwd.re <= wdata[`PHS_DWJ-1:0];
					phs_avg_pkg::REG_FWD_IM: gain_q.fwd.im <= wdata[`PHS_DWJ-1:0];
					phs_avg_pkg::REG_REV_RE: begin
						gain_q.rev.re <= wdata[`PHS_DWJ-1:0];
						gain_q.rev.im <= wdata[2*`PHS_DWJ-1:`PHS_DWJ];
					end
					phs_avg_pkg::REG_CTRL:   int_clear <= wdata[0];
					// unknown offset, response only
					default: ;
				endcase
			end else if (bvalid && bready) begin
				bvalid <= 1'b0;
			end else if (awvalid && wvalid && !bvalid) begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end
		end
	end

	// second stage toward the multipliers
	// new gains reach the sample two cycles after bvalid
	always_ff @(posedge clk) begin
		if (reset) begin
			gains <= '0;
		end else begin
			gains <= gain_q;
		end
	end

	// readback, forward components sign extended
	always_comb begin
		case (phs_avg_pkg::reg_addr_e'(araddr))
			phs_avg_pkg::REG_FWD_RE: rd_mux = {{EXT_W{gain_q.fwd.re[`PHS_DWJ-1]}}, gain_q.fwd.re};
			phs_avg_pkg::REG_FWD_IM: rd_mux = {{EXT_W{gain_q.fwd.im[`PHS_DWJ-1]}}, gain_q.fwd.im};
			phs_avg_pkg::REG_REV_RE: rd_mux = {gain_q.rev.im, gain_q.rev.re};
			// control is write-only
			default:                 rd_mux = '0;
		endcase
	end

	// read channel
	// arready stays low while a response waits for rready
	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
		end else if (rd_fire) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
		end else if (rvalid && rready) begin
			arready <= 1'b1;
			rvalid  <= 1'b0;
		end else if (!rvalid) begin
			arready <= 1'b1;
		end
	end

	// read data captured at acceptance
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rdata <= rd_mux;
		end
	end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/10ps

// testbench clock, 100 ns period, and power-on reset
module tb_clk_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset spans four rising edges
	// released just after the fourth, ahead of the stimulus drive point
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
	end

endmodule
